// ==== flist.f ====
src/grn_pkg.sv
src/fifo_if.sv
src/sync_fifo.sv
src/input_filter.sv
src/network_graph.sv
src/attractor_ctrl.sv
src/regulator_network.sv
sim/tb_regulator_network.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_regulator_network \
  -f flist.f -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat build.log; cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

// ==== sim/tb_regulator_network.sv ====
`timescale 1ns/1ps

module tb_regulator_network
  import grn_pkg::*;
();

  localparam bit tb_id      = 1'b0;
  localparam int n_table    = 16;
  localparam int n_batches  = 8;
  localparam int wait_limit = 5000;

  typedef struct packed {
    logic   tag;
    state_t upper;
    state_t lower;
    logic   accept;
  } stim_t;

  logic                       clk;
  logic                       arst_n;
  logic                       start;
  logic                       data_in_valid;
  logic [host_word_w-1:0]     data_in;
  logic                       end_data_in;
  logic                       read_data_en;
  logic                       has_data_out;
  logic                       has_lst3_data_out;
  logic [$bits(result_t)-1:0] data_out;
  logic                       task_done;

  stim_t   tbl [n_table];
  result_t exp_q [$];
  int      errors;
  int      checks;
  int      tests_run;
  int      tests_failed;
  int      results_read;
  bit      aborted;

  regulator_network #(
    .id (tb_id)
  ) i_dut (
    .clk               (clk),
    .arst_n            (arst_n),
    .start             (start),
    .data_in_valid     (data_in_valid),
    .data_in           (data_in),
    .end_data_in       (end_data_in),
    .read_data_en      (read_data_en),
    .has_data_out      (has_data_out),
    .has_lst3_data_out (has_lst3_data_out),
    .data_out          (data_out),
    .task_done         (task_done)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Inputs change and outputs are sampled 1 ns after the edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [78:0] got,
                             input logic [78:0] exp);
    checks++;
    assert (got == exp) else begin
      $display("CHECK FAILED %s got %0h expected %0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_mark);
    tests_run++;
    if (errors > err_mark) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_mark);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // Floyd cycle search in software
  function automatic result_t floyd_model(input state_t x0);
    state_t      t;
    state_t      h;
    logic [20:0] mu;
    logic [15:0] lam;
    result_t     r;
    t = net_next(x0);
    h = net_next(net_next(x0));
    while (t != h) begin
      t = net_next(t);
      h = net_next(net_next(h));
    end
    t  = x0;
    mu = '0;
    while (t != h) begin
      t  = net_next(t);
      h  = net_next(h);
      mu = mu + 21'd1;
    end
    // Period counted modulo 2^16 by the counter width
    lam = 16'd1;
    h   = net_next(t);
    while (h != t) begin
      h   = net_next(h);
      lam = lam + 16'd1;
    end
    r.start  = x0;
    r.entry  = t;
    r.mu     = mu;
    r.lambda = lam;
    return r;
  endfunction

  task automatic queue_pair(input state_t upper, input state_t lower);
    exp_q.push_back(floyd_model(upper));
    exp_q.push_back(floyd_model(lower));
  endtask

  task automatic send_word(input logic tag, input state_t upper, input state_t lower);
    data_in       = {tag, upper, lower};
    data_in_valid = 1'b1;
    tick();
    data_in_valid = 1'b0;
  endtask

  task automatic pulse_start();
    start = 1'b1;
    tick();
    start = 1'b0;
  endtask

  task automatic pulse_end();
    end_data_in = 1'b1;
    tick();
    end_data_in = 1'b0;
  endtask

  task automatic wait_done(input int limit);
    int cnt;
    cnt = 0;
    while (!task_done && cnt < limit) begin
      tick();
      cnt++;
    end
    if (!task_done) begin
      $display("Timeout: task_done stayed low for %0d cycles", limit);
      errors++;
      aborted = 1'b1;
    end
  endtask

  // Pops whatever the DUT still holds and counts it
  task automatic drain_leftover(output int n);
    n = 0;
    while (has_data_out && n < wait_limit) begin
      read_data_en = 1'b1;
      tick();
      read_data_en = 1'b0;
      n++;
    end
  endtask

  // Waits for the head result, compares it with the model and pops it
  task automatic read_result();
    result_t got;
    result_t exp;
    int      cnt;
    cnt = 0;
    while (!has_data_out && cnt < wait_limit) begin
      tick();
      cnt++;
    end
    if (!has_data_out) begin
      $display("Timeout: result %0d did not arrive within %0d cycles", results_read, wait_limit);
      errors++;
      aborted = 1'b1;
    end else begin
      got = data_out;
      exp = exp_q.pop_front();
      check_value($sformatf("data_out.start (result %0d)", results_read),
                  79'(got.start), 79'(exp.start));
      check_value($sformatf("data_out.entry (result %0d)", results_read),
                  79'(got.entry), 79'(exp.entry));
      check_value($sformatf("data_out.mu (result %0d)", results_read),
                  79'(got.mu), 79'(exp.mu));
      check_value($sformatf("data_out.lambda (result %0d)", results_read),
                  79'(got.lambda), 79'(exp.lambda));
      // All zeros and all ones map onto themselves
      if (exp.start == '0 || exp.start == '1) begin
        check_value("data_out.mu (fixed point)", 79'(got.mu), 79'(0));
        check_value("data_out.lambda (fixed point)", 79'(got.lambda), 79'(1));
      end
      read_data_en = 1'b1;
      tick();
      read_data_en = 1'b0;
      results_read++;
    end
  endtask

  task automatic fill_table();
    tbl[0] = '{1'b0, 21'h000000, 21'h1fffff, 1'b1};
    tbl[1] = '{1'b0, 21'h000001, 21'h100000, 1'b1};
    tbl[2] = '{1'b1, 21'h0000ff, 21'h000000, 1'b0};
    tbl[3] = '{1'b0, 21'h000080, 21'h000400, 1'b1};
    tbl[4] = '{1'b0, 21'h1fffff, 21'h000000, 1'b1};
    tbl[5] = '{1'b1, 21'h1fffff, 21'h000001, 1'b0};
    tbl[6] = '{1'b0, 21'h155555, 21'h0aaaaa, 1'b1};
    tbl[7] = '{1'b0, 21'h000002, 21'h010000, 1'b1};
    for (int i = 8; i < n_table; i++) begin
      tbl[i].tag    = 1'($urandom);
      tbl[i].upper  = state_t'($urandom);
      tbl[i].lower  = state_t'($urandom);
      tbl[i].accept = (tbl[i].tag == tb_id);
    end
  endtask

  initial begin
    int unsigned seed_val;
    int          err_mark;
    int          matching;
    int          leftover;
    state_t      up;
    state_t      lo;
    seed_val      = $urandom(32'h57c0f1da);
    errors        = 0;
    checks        = 0;
    tests_run     = 0;
    tests_failed  = 0;
    results_read  = 0;
    matching      = 0;
    leftover      = 0;
    aborted       = 1'b0;
    arst_n        = 1'b0;
    start         = 1'b0;
    data_in_valid = 1'b0;
    data_in       = '0;
    end_data_in   = 1'b0;
    read_data_en  = 1'b0;
    fill_table();
    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;
    tick();

    err_mark = errors;
    check_value("has_data_out", 79'(has_data_out), 79'(0));
    check_value("task_done", 79'(task_done), 79'(0));
    check_value("has_lst3_data_out", 79'(has_lst3_data_out), 79'(1));
    report_test("reset_values", err_mark);

    err_mark = errors;
    pulse_start();
    for (int i = 0; i < n_table && !aborted; i++) begin
      send_word(tbl[i].tag, tbl[i].upper, tbl[i].lower);
      if (tbl[i].accept) begin
        matching++;
        queue_pair(tbl[i].upper, tbl[i].lower);
        read_result();
        read_result();
      end
    end
    report_test("table_results", err_mark);

    if (!aborted) begin
      err_mark = errors;
      check_value("task_done (before end)", 79'(task_done), 79'(0));
      pulse_end();
      wait_done(wait_limit);
      check_value("has_data_out (at done)", 79'(has_data_out), 79'(0));
      pulse_start();
      check_value("task_done (after start)", 79'(task_done), 79'(0));
      report_test("done_level", err_mark);
    end

    // Every result the DUT made is either read already or still queued
    if (!aborted) begin
      err_mark = errors;
      drain_leftover(leftover);
      check_value("result count", 79'(results_read + leftover), 79'(2 * matching));
      report_test("tag_filter", err_mark);
    end

    // Host stays idle until the output FIFO is full
    if (!aborted) begin
      err_mark = errors;
      for (int b = 0; b < n_batches && !aborted; b++) begin
        for (int k = 0; k < 4; k++) begin
          up = state_t'($urandom);
          lo = state_t'($urandom);
          queue_pair(up, lo);
          send_word(tb_id, up, lo);
        end
        pulse_end();
        wait_done(8 * wait_limit);
        pulse_start();
        if (b == 0) begin
          check_value("has_lst3_data_out (8 pending)", 79'(has_lst3_data_out), 79'(0));
        end
      end
      check_value("has_data_out (64 pending)", 79'(has_data_out), 79'(1));
      // Extra pair is held by the controller until slots free up
      up = state_t'($urandom);
      lo = state_t'($urandom);
      queue_pair(up, lo);
      send_word(tb_id, up, lo);
      pulse_end();
      for (int k = 0; k < 8 && !aborted; k++) begin
        check_value("has_lst3_data_out (backlog)", 79'(has_lst3_data_out), 79'(0));
        read_result();
      end
      if (!aborted) begin
        wait_done(2 * wait_limit);
      end
      while (has_data_out && exp_q.size() > 0 && !aborted) begin
        check_value("has_lst3_data_out (drain)", 79'(has_lst3_data_out),
                    79'(exp_q.size() <= 2));
        read_result();
      end
      check_value("results left in model", 79'(exp_q.size()), 79'(0));
      check_value("has_data_out (drained)", 79'(has_data_out), 79'(0));
      check_value("has_lst3_data_out (drained)", 79'(has_lst3_data_out), 79'(1));
      report_test("backlog", err_mark);
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && !aborted) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== src/attractor_ctrl.sv ====
`timescale 1ns/1ps

module attractor_ctrl
  import grn_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  input  logic   start,
  input  logic   end_data_in,
  fifo_if.pop    rd,
  fifo_if.push   wr,
  output logic   load_s0,
  output logic   load_s1,
  output logic   step_s0,
  output logic   step_s1,
  output state_t init_state,
  input  state_t s0,
  input  state_t s1,
  output logic   done
);

  typedef enum logic [3:0] {
    st_idle,
    st_load,
    st_meet_a,
    st_meet_b,
    st_meet_chk,
    st_trans_init,
    st_trans,
    st_per_init,
    st_per,
    st_write
  } ctrl_state_t;

  ctrl_state_t state;
  ctrl_state_t state_next;

  pair_t       pair_q;
  logic        half_q;
  logic [20:0] mu_q;
  logic [15:0] lam_q;
  logic        end_d1;
  logic        end_q;
  logic        same;

  assign same = (s0 == s1);

  // Upper state first
  assign init_state = half_q ? pair_q[n_genes-1:0] : pair_q[2*n_genes-1:n_genes];

  always_comb begin
    state_next = state;
    load_s0    = 1'b0;
    load_s1    = 1'b0;
    step_s0    = 1'b0;
    step_s1    = 1'b0;
    rd.re      = 1'b0;
    wr.we      = 1'b0;
    case (state)
      st_idle: begin
        if (!rd.empty) begin
          rd.re      = 1'b1;
          state_next = st_load;
        end
      end
      st_load: begin
        load_s0    = 1'b1;
        load_s1    = 1'b1;
        state_next = st_meet_a;
      end
      st_meet_a: begin
        step_s0    = 1'b1;
        step_s1    = 1'b1;
        state_next = st_meet_b;
      end
      // Second hare step of the meeting phase
      st_meet_b: begin
        step_s1    = 1'b1;
        state_next = st_meet_chk;
      end
      st_meet_chk: begin
        if (same) begin
          state_next = st_trans_init;
        end else begin
          step_s0    = 1'b1;
          step_s1    = 1'b1;
          state_next = st_meet_b;
        end
      end
      st_trans_init: begin
        load_s0    = 1'b1;
        state_next = st_trans;
      end
      st_trans: begin
        if (same) begin
          state_next = st_per_init;
        end else begin
          step_s0 = 1'b1;
          step_s1 = 1'b1;
        end
      end
      st_per_init: begin
        step_s1    = 1'b1;
        state_next = st_per;
      end
      // Tortoise sits on the entry state here
      st_per: begin
        if (same) begin
          state_next = st_write;
        end else begin
          step_s1 = 1'b1;
        end
      end
      st_write: begin
        if (!wr.full) begin
          wr.we      = 1'b1;
          state_next = half_q ? st_idle : st_load;
        end
      end
      default: state_next = st_idle;
    endcase
  end

  always_comb begin
    wr.din        = '0;
    wr.din.start  = init_state;
    wr.din.entry  = s0;
    wr.din.mu     = mu_q;
    wr.din.lambda = lam_q;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= st_idle;
      half_q <= 1'b0;
      mu_q   <= '0;
      lam_q  <= '0;
    end else begin
      state <= state_next;
      case (state)
        st_idle:       half_q <= 1'b0;
        st_trans_init: mu_q   <= '0;
        st_trans:      if (!same) mu_q <= mu_q + 1'b1;
        st_per_init:   lam_q  <= 16'd1;
        st_per:        if (!same) lam_q <= lam_q + 1'b1;
        st_write:      if (!wr.full) half_q <= 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd.re) begin
      pair_q <= rd.dout;
    end
  end

  // End marker is delayed so a word still in the filter register counts as pending
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      end_d1 <= 1'b0;
      end_q  <= 1'b0;
    end else if (start) begin
      end_d1 <= 1'b0;
      end_q  <= 1'b0;
    end else begin
      end_d1 <= end_data_in;
      if (end_d1) begin
        end_q <= 1'b1;
      end
    end
  end

  assign done = end_q & rd.empty & (state == st_idle);

endmodule

// ==== src/fifo_if.sv ====
`timescale 1ns/1ps

interface fifo_if #(
  parameter type payload_t = logic
);

  logic     we;
  payload_t din;
  logic     full;
  logic     almost_full;

  logic     re;
  payload_t dout;
  logic     empty;
  logic     almost_empty;

  // FIFO side
  modport writer (input we, din, output full, almost_full);
  modport reader (input re, output dout, empty, almost_empty);

  // Client side
  modport push (output we, din, input full, almost_full);
  modport pop (output re, input dout, empty, almost_empty);

endinterface

// ==== src/grn_pkg.sv ====
package grn_pkg;

  localparam int n_genes = 21;

  // Host word is one tag bit over a pair of states
  localparam int host_word_w = 2 * n_genes + 1;

  // FIFO depth exponents
  localparam int in_depth_bits  = 3;
  localparam int out_depth_bits = 6;

  // Almost full with two or fewer free slots, almost empty with two or fewer words
  localparam int almost_full_margin = 2;
  localparam int almost_empty_level = 2;

  typedef logic [n_genes-1:0] state_t;

  // Upper state first, then lower state
  typedef logic [2*n_genes-1:0] pair_t;

  typedef struct packed {
    state_t      start;
    state_t      entry;
    logic [20:0] mu;
    logic [15:0] lambda;
  } result_t;

  // One synchronous update of the whole network
  function automatic state_t net_next(input state_t s);
    state_t n;
    n[0] = s[1] | s[7];
    for (int i = 1; i < n_genes; i++) begin
      n[i] = s[(i + 1) % n_genes] & s[(i + 2) % n_genes];
    end
    return n;
  endfunction

endpackage

// ==== src/input_filter.sv ====
`timescale 1ns/1ps

module input_filter
  import grn_pkg::*;
#(
  parameter bit id = 1'b0
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   start,
  input  logic                   data_in_valid,
  input  logic [host_word_w-1:0] data_in,
  fifo_if.push                   wr
);

  logic  started;
  logic  accept;
  logic  we_q;
  pair_t pair_q;

  // Tag bit must match this instance
  assign accept = started & data_in_valid & (data_in[host_word_w-1] == id) & ~wr.full;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      started <= 1'b0;
      we_q    <= 1'b0;
    end else begin
      if (start) begin
        started <= 1'b1;
      end
      we_q <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pair_q <= data_in[host_word_w-2:0];
    end
  end

  assign wr.we  = we_q;
  assign wr.din = pair_q;

endmodule

// ==== src/network_graph.sv ====
`timescale 1ns/1ps

module network_graph
  import grn_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  input  logic   load_s0,
  input  logic   load_s1,
  input  logic   step_s0,
  input  logic   step_s1,
  input  state_t init_state,
  output state_t s0,
  output state_t s1
);

  // Tortoise
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s0 <= '0;
    end else if (load_s0) begin
      s0 <= init_state;
    end else if (step_s0) begin
      s0 <= net_next(s0);
    end
  end

  // Hare
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1 <= '0;
    end else if (load_s1) begin
      s1 <= init_state;
    end else if (step_s1) begin
      s1 <= net_next(s1);
    end
  end

endmodule

// ==== src/regulator_network.sv ====
`timescale 1ns/1ps

module regulator_network
  import grn_pkg::*;
#(
  parameter bit id = 1'b0
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       start,
  input  logic                       data_in_valid,
  input  logic [host_word_w-1:0]     data_in,
  input  logic                       end_data_in,
  input  logic                       read_data_en,
  output logic                       has_data_out,
  output logic                       has_lst3_data_out,
  output logic [$bits(result_t)-1:0] data_out,
  output logic                       task_done
);

  fifo_if #(.payload_t(pair_t))   in_bus ();
  fifo_if #(.payload_t(result_t)) out_bus ();

  logic   load_s0;
  logic   load_s1;
  logic   step_s0;
  logic   step_s1;
  state_t init_state;
  state_t s0;
  state_t s1;

  // Host drains the output FIFO directly
  assign out_bus.re        = read_data_en;
  assign data_out          = out_bus.dout;
  assign has_data_out      = ~out_bus.empty;
  assign has_lst3_data_out = out_bus.almost_empty;

  input_filter #(
    .id (id)
  ) i_input_filter (
    .clk           (clk),
    .arst_n        (arst_n),
    .start         (start),
    .data_in_valid (data_in_valid),
    .data_in       (data_in),
    .wr            (in_bus.push)
  );

  sync_fifo #(
    .payload_t  (pair_t),
    .depth_bits (in_depth_bits)
  ) i_fifo_in (
    .clk    (clk),
    .arst_n (arst_n),
    .wr     (in_bus.writer),
    .rd     (in_bus.reader)
  );

  sync_fifo #(
    .payload_t  (result_t),
    .depth_bits (out_depth_bits)
  ) i_fifo_out (
    .clk    (clk),
    .arst_n (arst_n),
    .wr     (out_bus.writer),
    .rd     (out_bus.reader)
  );

  attractor_ctrl i_attractor_ctrl (
    .clk         (clk),
    .arst_n      (arst_n),
    .start       (start),
    .end_data_in (end_data_in),
    .rd          (in_bus.pop),
    .wr          (out_bus.push),
    .load_s0     (load_s0),
    .load_s1     (load_s1),
    .step_s0     (step_s0),
    .step_s1     (step_s1),
    .init_state  (init_state),
    .s0          (s0),
    .s1          (s1),
    .done        (task_done)
  );

  network_graph i_network_graph (
    .clk        (clk),
    .arst_n     (arst_n),
    .load_s0    (load_s0),
    .load_s1    (load_s1),
    .step_s0    (step_s0),
    .step_s1    (step_s1),
    .init_state (init_state),
    .s0         (s0),
    .s1         (s1)
  );

endmodule

// ==== src/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo
  import grn_pkg::*;
#(
  parameter type payload_t  = logic,
  parameter int  depth_bits = 3
) (
  input  logic clk,
  input  logic arst_n,
  fifo_if.writer wr,
  fifo_if.reader rd
);

  localparam int depth = 1 << depth_bits;

  payload_t mem [depth];

  logic [depth_bits-1:0] wr_ptr;
  logic [depth_bits-1:0] rd_ptr;
  logic [depth_bits:0]   count;
  logic [depth_bits:0]   count_next;

  logic do_write;
  logic do_read;

  assign do_write = wr.we & ~wr.full;
  assign do_read  = rd.re & ~rd.empty;

  always_comb begin
    count_next = count;
    if (do_write && !do_read) begin
      count_next = count + 1'b1;
    end else if (do_read && !do_write) begin
      count_next = count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= wr.din;
    end
  end

  // Show-ahead head word
  assign rd.dout = mem[rd_ptr];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr          <= '0;
      rd_ptr          <= '0;
      count           <= '0;
      rd.empty        <= 1'b1;
      rd.almost_empty <= 1'b1;
      wr.full         <= 1'b0;
      wr.almost_full  <= 1'b0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count_next;
      // Flags follow the count after this edge
      rd.empty        <= (count_next == 0);
      rd.almost_empty <= (count_next <= almost_empty_level);
      wr.full         <= (count_next == depth);
      wr.almost_full  <= (count_next >= depth - almost_full_margin);
    end
  end

endmodule
